/* include/motion_consts.svh */
`ifndef MOTION_CONSTS_SVH
`define MOTION_CONSTS_SVH

// Command opcodes, top byte of a header word
`define CMD_COORDINATED_STEP 8'h01
`define CMD_CLK_DIVISOR 8'h03
`define CMD_MOTOR_ENABLE 8'h0A
`define CMD_API_VERSION 8'hFE

// API version reported to the host
`define VERSION_MAJOR 8'd0
`define VERSION_MINOR 8'd2
`define VERSION_PATCH 8'd1

// Move ring size, depth must be a power of two
`define MOVE_BUFFER_DEPTH 4
`define MOVE_BUFFER_BITS 2

// Tick divisor out of reset
`define DEFAULT_CLOCK_DIVISOR 8'd40

`endif

/* rtl/motion_pkg.sv */
`default_nettype none

package motion_pkg;

  // Header word layout
  // Opcode in the top byte, argument below it
  typedef struct packed {
    logic [7:0]  cmd;
    // Bit 0 is dir or enable flag, bits 7:0 the divisor
    logic [55:0] arg;
  } cmd_header_t;

  // One SPI word
  // Raw view for move operands, header view for commands
  typedef union packed {
    logic [63:0] raw;
    cmd_header_t hdr;
  } spi_word_t;

endpackage

`default_nettype wire

/* rtl/move_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface move_if;

  // Entry at the ring read index
  logic [63:0]        duration;
  // Q32.32 steps per tick
  logic signed [63:0] increment;
  // Q32.32 change of increment per tick
  logic signed [63:0] accel;
  logic               dir;
  // High while the ring holds a move
  logic               pending;
  // One-cycle pulse when the timer is done with the entry
  logic               consumed;

  modport producer (
    output duration, increment, accel, dir, pending,
    input  consumed
  );

  modport consumer (
    input  duration, increment, accel, dir, pending,
    output consumed
  );

endinterface

`default_nettype wire

/* rtl/spi_word.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_word import motion_pkg::*; (
  input  logic      CLK,
  input  logic      resetn,
  input  logic      sck,
  input  logic      cs_n,
  input  logic      copi,
  output logic      cipo,
  input  spi_word_t tx_word,
  output spi_word_t rx_word,
  output logic      word_valid
);

  // Two sync flops, a sample stage and a delayed copy for edges
  logic [3:0]  sck_sync;
  logic [3:0]  cs_sync;
  logic [2:0]  copi_sync;
  logic        sck_rise;
  logic        sck_fall;
  logic        cs_fall;
  logic        cs_idle;
  logic [5:0]  bit_cnt;
  logic [63:0] rx_shift;
  logic [63:0] tx_shift;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_sync  <= '0;
      // Bus idles deselected
      cs_sync   <= '1;
      copi_sync <= '0;
    end else begin
      sck_sync  <= {sck_sync[2:0], sck};
      cs_sync   <= {cs_sync[2:0], cs_n};
      copi_sync <= {copi_sync[1:0], copi};
    end
  end

  // Mode 0 edges
  assign sck_rise = sck_sync[2] & ~sck_sync[3];
  assign sck_fall = ~sck_sync[2] & sck_sync[3];
  assign cs_fall  = ~cs_sync[2] & cs_sync[3];
  assign cs_idle  = cs_sync[2];

  // Bit counter wraps every 64 bits
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_cnt    <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= 1'b0;
      if (cs_idle) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt    <= bit_cnt + 6'd1;
        word_valid <= (bit_cnt == 6'd63);
      end
    end
  end

  // Receive side, MSB first
  always_ff @(posedge CLK) begin
    if (!cs_idle && sck_rise) begin
      rx_shift <= {rx_shift[62:0], copi_sync[2]};
    end
  end

  assign rx_word = spi_word_t'(rx_shift);

  // Reply loads on select and on the falling edge after each 64th bit
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      tx_shift <= '0;
    end else if (cs_fall) begin
      tx_shift <= tx_word.raw;
    end else if (!cs_idle && sck_fall) begin
      if (bit_cnt == 6'd0) begin
        tx_shift <= tx_word.raw;
      end else begin
        tx_shift <= {tx_shift[62:0], 1'b0};
      end
    end
  end

  assign cipo = tx_shift[63];

endmodule

`default_nettype wire

/* rtl/cmd_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "motion_consts.svh"

module cmd_decoder import motion_pkg::*; (
  input  logic      CLK,
  input  logic      resetn,
  input  spi_word_t rx_word,
  input  logic      word_valid,
  output spi_word_t tx_word,
  output logic      enable,
  output logic [7:0] clock_divisor,
  output logic      buffer_ready,
  move_if.producer  mv
);

  localparam int DEPTH = `MOVE_BUFFER_DEPTH;
  localparam int BITS  = `MOVE_BUFFER_BITS;

  // Move ring storage
  logic [63:0]        dur_mem [DEPTH];
  logic signed [63:0] inc_mem [DEPTH];
  logic signed [63:0] acc_mem [DEPTH];
  logic [DEPTH-1:0]   dir_mem;

  // Pointers carry one wrap bit
  logic [BITS:0]      wr_ptr;
  logic [BITS:0]      rd_ptr;
  logic [BITS-1:0]    wr_idx;
  logic [BITS-1:0]    rd_idx;
  logic               full;
  logic               empty;

  // Message state
  cmd_header_t        hdr_q;
  logic [1:0]         word_cnt;
  logic               msg_open;
  logic [63:0]        stage_dur;
  logic signed [63:0] stage_inc;

  assign wr_idx = wr_ptr[BITS-1:0];
  assign rd_idx = rd_ptr[BITS-1:0];
  assign empty  = (wr_ptr == rd_ptr);
  assign full   = (wr_ptr[BITS] != rd_ptr[BITS]) && (wr_idx == rd_idx);

  // Only the move command spans several words
  assign msg_open = (word_cnt != 2'd0) && (hdr_q.cmd == `CMD_COORDINATED_STEP);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      hdr_q         <= '0;
      word_cnt      <= '0;
      enable        <= 1'b0;
      clock_divisor <= `DEFAULT_CLOCK_DIVISOR;
      tx_word       <= '0;
      wr_ptr        <= '0;
    end else if (word_valid) begin
      // Reply lasts one word only
      tx_word <= '0;
      if (!msg_open) begin
        hdr_q <= rx_word.hdr;
        case (rx_word.hdr.cmd)
          `CMD_COORDINATED_STEP: word_cnt <= 2'd1;
          `CMD_MOTOR_ENABLE:     enable <= rx_word.hdr.arg[0];
          `CMD_CLK_DIVISOR:      clock_divisor <= rx_word.hdr.arg[7:0];
          `CMD_API_VERSION: begin
            tx_word.raw <= {40'd0, `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH};
          end
          default: ;
        endcase
      end else if (word_cnt == 2'd3) begin
        // Last operand, entry is committed below
        word_cnt <= '0;
        // Full ring drops the move
        if (!full) begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end else begin
        word_cnt <= word_cnt + 2'd1;
      end
    end
  end

  // Operands are staged so a slot in use is never touched
  always_ff @(posedge CLK) begin
    if (word_valid && msg_open) begin
      case (word_cnt)
        2'd1: stage_dur <= rx_word.raw;
        2'd2: stage_inc <= rx_word.raw;
        2'd3: begin
          if (!full) begin
            dur_mem[wr_idx] <= stage_dur;
            inc_mem[wr_idx] <= stage_inc;
            acc_mem[wr_idx] <= rx_word.raw;
            dir_mem[wr_idx] <= hdr_q.arg[0];
          end
        end
        default: ;
      endcase
    end
  end

  // Timer releases the head entry
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      rd_ptr <= '0;
    end else if (mv.consumed) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  assign mv.duration  = dur_mem[rd_idx];
  assign mv.increment = inc_mem[rd_idx];
  assign mv.accel     = acc_mem[rd_idx];
  assign mv.dir       = dir_mem[rd_idx];
  assign mv.pending   = !empty;
  assign buffer_ready = !full;

endmodule

`default_nettype wire

/* rtl/dda_timer.sv */
`timescale 1ns/10ps
`default_nettype none

module dda_timer (
  input  logic       CLK,
  input  logic       resetn,
  input  logic       halt,
  input  logic [7:0] clock_divisor,
  move_if.consumer   mv,
  output logic       step,
  output logic       dir,
  output logic       move_done
);

  logic               running;
  logic [7:0]         div_cnt;
  logic [63:0]        tick_cnt;
  // Q32.32 position within the current move
  logic signed [63:0] accum;
  logic signed [63:0] accum_next;
  logic signed [63:0] live_inc;
  logic               tick;
  logic               last_tick;
  logic               start;

  // Greater-or-equal keeps the period sane if the divisor drops mid-move
  assign tick      = running && !halt && (div_cnt >= clock_divisor);
  assign last_tick = tick && ((tick_cnt + 64'd1) >= mv.duration);
  // Wait out the done cycle so the old head is not replayed
  assign start      = !running && mv.pending && !move_done;
  assign accum_next = accum + live_inc;

  // Release the ring entry with the done pulse
  assign mv.consumed = move_done;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      running   <= 1'b0;
      div_cnt   <= '0;
      tick_cnt  <= '0;
      accum     <= '0;
      step      <= 1'b0;
      move_done <= 1'b0;
      dir       <= 1'b0;
    end else begin
      step      <= 1'b0;
      move_done <= 1'b0;
      if (start) begin
        running  <= 1'b1;
        div_cnt  <= '0;
        tick_cnt <= '0;
        dir      <= mv.dir;
      end else if (running && !halt) begin
        if (tick) begin
          div_cnt  <= '0;
          tick_cnt <= tick_cnt + 64'd1;
          // Step on any change of the integer part
          step     <= (accum_next[63:32] != accum[63:32]);
          if (last_tick) begin
            accum     <= '0;
            running   <= 1'b0;
            move_done <= 1'b1;
          end else begin
            accum <= accum_next;
          end
        end else begin
          div_cnt <= div_cnt + 8'd1;
        end
      end
    end
  end

  // Velocity ramps by accel once per tick
  always_ff @(posedge CLK) begin
    if (start) begin
      live_inc <= mv.increment;
    end else if (tick) begin
      live_inc <= live_inc + mv.accel;
    end
  end

endmodule

`default_nettype wire

/* rtl/motion_core.sv */
`timescale 1ns/10ps
`default_nettype none

module motion_core import motion_pkg::*; (
  input  logic CLK,
  input  logic resetn,
  input  logic sck,
  input  logic cs_n,
  input  logic copi,
  output logic cipo,
  input  logic halt,
  output logic step,
  output logic dir,
  output logic enable,
  output logic move_done,
  output logic buffer_ready
);

  spi_word_t  rx_word;
  spi_word_t  tx_word;
  logic       word_valid;
  logic [7:0] clock_divisor;

  // Head of the move ring, decoder to timer
  move_if mv ();

  // SPI word receiver and reply shifter
  spi_word u_spi (
    .CLK        (CLK),
    .resetn     (resetn),
    .sck        (sck),
    .cs_n       (cs_n),
    .copi       (copi),
    .cipo       (cipo),
    .tx_word    (tx_word),
    .rx_word    (rx_word),
    .word_valid (word_valid)
  );

  // Command FSM, settings and move ring
  cmd_decoder u_dec (
    .CLK           (CLK),
    .resetn        (resetn),
    .rx_word       (rx_word),
    .word_valid    (word_valid),
    .tx_word       (tx_word),
    .enable        (enable),
    .clock_divisor (clock_divisor),
    .buffer_ready  (buffer_ready),
    .mv            (mv)
  );

  // Step generation
  dda_timer u_dda (
    .CLK           (CLK),
    .resetn        (resetn),
    .halt          (halt),
    .clock_divisor (clock_divisor),
    .mv            (mv),
    .step          (step),
    .dir           (dir),
    .move_done     (move_done)
  );

endmodule

`default_nettype wire

/* tb/motion_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

`include "motion_consts.svh"

module motion_asserts #(
  // Timer side checks the pulses, decoder side checks the ring
  parameter bit TIMER_SIDE = 1'b1
) (
  input logic                       CLK,
  input logic                       resetn,
  input logic                       step_pulse,
  input logic                       done_pulse,
  input logic                       consumed,
  input logic                       pending,
  input logic [`MOVE_BUFFER_BITS:0] wr_ptr,
  input logic [`MOVE_BUFFER_BITS:0] rd_ptr,
  input logic                       ready
);

  // Entries held, pointers carry a wrap bit
  logic [`MOVE_BUFFER_BITS:0] fill;

  assign fill = wr_ptr - rd_ptr;

  if (TIMER_SIDE) begin : g_timer
    // Output pulses last exactly one cycle
    step_one_cycle: assert property (@(posedge CLK) disable iff (!resetn)
      step_pulse |=> !step_pulse)
      else $error("step held high for two cycles");

    done_one_cycle: assert property (@(posedge CLK) disable iff (!resetn)
      done_pulse |=> !done_pulse)
      else $error("move_done held high for two cycles");

    // Only a queued entry can be released
    consume_needs_entry: assert property (@(posedge CLK) disable iff (!resetn)
      consumed |-> pending)
      else $error("consumed with an empty move ring");
  end else begin : g_ring
    // Back-pressure flag low only with every slot taken
    ready_tracks_full: assert property (@(posedge CLK) disable iff (!resetn)
      ready == (fill != `MOVE_BUFFER_DEPTH))
      else $error("buffer_ready disagrees with ring fill level");
  end

endmodule

// Timer side, pulse rules
bind dda_timer motion_asserts #(.TIMER_SIDE(1'b1)) u_dda_asserts (
  .CLK        (CLK),
  .resetn     (resetn),
  .step_pulse (step),
  .done_pulse (move_done),
  .consumed   (mv.consumed),
  .pending    (mv.pending),
  .wr_ptr     ('0),
  .rd_ptr     ('0),
  .ready      (1'b1)
);

// Decoder side, ring rules
bind cmd_decoder motion_asserts #(.TIMER_SIDE(1'b0)) u_dec_asserts (
  .CLK        (CLK),
  .resetn     (resetn),
  .step_pulse (1'b0),
  .done_pulse (1'b0),
  .consumed   (1'b0),
  .pending    (1'b0),
  .wr_ptr     (wr_ptr),
  .rd_ptr     (rd_ptr),
  .ready      (buffer_ready)
);

`default_nettype wire

/* tb/tb_motion_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "motion_consts.svh"

module tb_motion_core import motion_pkg::*; ();

  // Budget: 10 random moves of up to 35 ticks plus one long move
  localparam int MAX_TICKS       = 10 * 35 + 200;
  localparam int SPI_WORDS       = 60;
  localparam int WORD_CYCLES     = 64 * 16 + 32;
  localparam int EXTRA_CYCLES    = 5000;
  localparam int WATCHDOG_CYCLES = MAX_TICKS * (`DEFAULT_CLOCK_DIVISOR + 1) * 2
                                   + SPI_WORDS * WORD_CYCLES + EXTRA_CYCLES;

  logic CLK;
  logic resetn;
  logic sck;
  logic cs_n;
  logic copi;
  logic cipo;
  logic halt;
  logic step;
  logic dir;
  logic enable;
  logic move_done;
  logic buffer_ready;

  int unsigned step_cnt;
  int unsigned done_cnt;
  int unsigned err_cnt;
  int unsigned check_cnt;
  // Expected dir of each outstanding move, oldest first
  logic        dir_q[$];
  logic [31:0] lfsr_state;

  motion_core dut (
    .CLK          (CLK),
    .resetn       (resetn),
    .sck          (sck),
    .cs_n         (cs_n),
    .copi         (copi),
    .cipo         (cipo),
    .halt         (halt),
    .step         (step),
    .dir          (dir),
    .enable       (enable),
    .move_done    (move_done),
    .buffer_ready (buffer_ready)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
  endtask

  // Q32.32 DDA, one step whenever the integer part moves
  function automatic int unsigned ref_dda_steps(input logic [63:0] dur,
                                                input logic signed [63:0] inc,
                                                input logic signed [63:0] acc);
    logic signed [63:0] pos;
    logic signed [63:0] nxt;
    logic signed [63:0] vel;
    int unsigned        n;
    int unsigned        steps;
    pos   = '0;
    vel   = inc;
    steps = 0;
    // Zero duration still plays one tick
    n = (dur == 64'd0) ? 1 : dur[31:0];
    for (int unsigned t = 0; t < n; t++) begin
      nxt = pos + vel;
      if (nxt[63:32] != pos[63:32]) begin
        steps++;
      end
      pos = nxt;
      vel = vel + acc;
    end
    return steps;
  endfunction

  // Patch in byte 0, minor in byte 1, major in byte 2
  function automatic spi_word_t ref_version();
    spi_word_t w;
    w.raw        = '0;
    w.raw[23:16] = `VERSION_MAJOR;
    w.raw[15:8]  = `VERSION_MINOR;
    w.raw[7:0]   = `VERSION_PATCH;
    return w;
  endfunction

  function automatic spi_word_t make_hdr(input logic [7:0] cmd, input logic [55:0] arg);
    spi_word_t w;
    w.hdr.cmd = cmd;
    w.hdr.arg = arg;
    return w;
  endfunction

  task automatic check_word(input string name, input spi_word_t got, input spi_word_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH %s: got %h expected %h", name, got.raw, exp.raw);
    end
  endtask

  task automatic check_count(input string name, input int unsigned got,
                             input int unsigned exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  // Cycle count within a window
  task automatic check_cycles(input string name, input int unsigned got,
                              input int unsigned lo, input int unsigned hi);
    check_cnt++;
    if (got < lo || got > hi) begin
      err_cnt++;
      $display("MISMATCH %s: got %h expected %h to %h", name, got, lo, hi);
    end
  endtask

  // Mode 0, 8 CLK per half sck period, one word per select
  task automatic spi_xfer(input spi_word_t tx, output spi_word_t rx);
    logic [63:0] shift;
    shift = '0;
    cs_n  = 1'b0;
    repeat (8) @(negedge CLK);
    for (int i = 63; i >= 0; i--) begin
      copi = tx.raw[i];
      repeat (8) @(negedge CLK);
      // Host samples cipo at the rising edge
      shift = {shift[62:0], cipo};
      sck   = 1'b1;
      repeat (8) @(negedge CLK);
      sck = 1'b0;
    end
    repeat (8) @(negedge CLK);
    cs_n = 1'b1;
    repeat (8) @(negedge CLK);
    rx.raw = shift;
  endtask

  // Header, then duration, increment and accel
  task automatic send_move(input logic d, input logic [63:0] dur, input logic [63:0] inc,
                           input logic [63:0] acc);
    spi_word_t w;
    spi_word_t rx;
    spi_xfer(make_hdr(`CMD_COORDINATED_STEP, {55'd0, d}), rx);
    w.raw = dur;
    spi_xfer(w, rx);
    w.raw = inc;
    spi_xfer(w, rx);
    w.raw = acc;
    spi_xfer(w, rx);
  endtask

  // Small positive velocity, accel too small to flip its sign
  task automatic pick_move(output logic d, output logic [63:0] dur, output logic [63:0] inc,
                           output logic [63:0] acc);
    logic [63:0] v;
    take_bits(5, v);
    dur = 64'd4 + v;
    take_bits(30, v);
    inc = 64'h1000_0000 + v;
    take_bits(22, v);
    acc = v - 64'h20_0000;
    take_bits(1, v);
    d = v[0];
  endtask

  task automatic play_move(input logic d, input logic [63:0] dur, input logic [63:0] inc,
                           input logic [63:0] acc, input logic [7:0] div);
    int unsigned sbase;
    int unsigned dbase;
    int unsigned span;
    int unsigned cyc;
    sbase = step_cnt;
    dbase = done_cnt;
    span  = dur[31:0] * (div + 1);
    // Queued before sending, the first step may come before the task returns
    dir_q.push_back(d);
    send_move(d, dur, inc, acc);
    // Counted from the last rising sck edge, 24 cycles before send_move returns
    cyc = 24;
    while (move_done !== 1'b1) begin
      @(negedge CLK);
      cyc++;
    end
    // Word sync, ring write and move start come on top of the ticks
    check_cycles("move length", cyc, span + 4, span + 8);
    wait (done_cnt != dbase);
    repeat (40) @(negedge CLK);
    check_count("move_done", done_cnt - dbase, 1);
    check_count("step", step_cnt - sbase, ref_dda_steps(dur, inc, acc));
  endtask

  // Pulse monitor, dir compared at every step
  always @(negedge CLK) begin
    if (resetn) begin
      if (step) begin
        step_cnt++;
        if (dir_q.size() == 0) begin
          err_cnt++;
          $display("Step pulse seen with no move outstanding");
        end else begin
          check_bit("dir", dir, dir_q[0]);
        end
      end
      if (move_done) begin
        done_cnt++;
        if (dir_q.size() == 0) begin
          err_cnt++;
          $display("move_done pulse seen with no move outstanding");
        end else begin
          void'(dir_q.pop_front());
        end
      end
    end
  end

  initial begin
    spi_word_t   rx;
    spi_word_t   dummy;
    logic [63:0] v;
    logic [7:0]  div;
    logic        mdir [4];
    logic [63:0] mdur [4];
    logic [63:0] minc [4];
    logic [63:0] macc [4];
    int unsigned sbase;
    int unsigned dbase;
    int unsigned held;
    int unsigned exp_steps;
    lfsr_state = 32'ha460f24c;
    step_cnt   = 0;
    done_cnt   = 0;
    err_cnt    = 0;
    check_cnt  = 0;
    resetn     = 1'b0;
    sck        = 1'b0;
    cs_n       = 1'b1;
    copi       = 1'b0;
    halt       = 1'b0;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    resetn = 1'b1;
    @(negedge CLK);
    check_bit("buffer_ready", buffer_ready, 1'b1);
    check_bit("enable", enable, 1'b0);
    check_bit("step", step, 1'b0);
    check_bit("move_done", move_done, 1'b0);
    check_bit("cipo", cipo, 1'b0);

    // Version reply leaves during the word after the request
    take_bits(32, v);
    dummy = make_hdr(8'h00, {24'd0, v[31:0]});
    spi_xfer(make_hdr(`CMD_API_VERSION, 56'd0), rx);
    spi_xfer(dummy, rx);
    check_word("cipo word", rx, ref_version());
    spi_xfer(dummy, rx);
    check_word("cipo word", rx, '0);

    spi_xfer(make_hdr(`CMD_MOTOR_ENABLE, 56'd1), rx);
    check_bit("enable", enable, 1'b1);
    spi_xfer(make_hdr(`CMD_MOTOR_ENABLE, 56'd0), rx);
    check_bit("enable", enable, 1'b0);

    // Same moves at two divisors, step counts must not change
    for (int m = 0; m < 3; m++) begin
      pick_move(mdir[m], mdur[m], minc[m], macc[m]);
    end
    div = `DEFAULT_CLOCK_DIVISOR;
    for (int p = 0; p < 2; p++) begin
      if (p == 1) begin
        div = 8'd5;
        spi_xfer(make_hdr(`CMD_CLK_DIVISOR, {48'd0, div}), rx);
      end
      for (int m = 0; m < 3; m++) begin
        play_move(mdir[m], mdur[m], minc[m], macc[m], div);
      end
    end

    // Fill the ring while halted
    for (int m = 0; m < 4; m++) begin
      pick_move(mdir[m], mdur[m], minc[m], macc[m]);
    end
    halt      = 1'b1;
    sbase     = step_cnt;
    dbase     = done_cnt;
    exp_steps = 0;
    for (int m = 0; m < 4; m++) begin
      dir_q.push_back(mdir[m]);
      send_move(mdir[m], mdur[m], minc[m], macc[m]);
      exp_steps += ref_dda_steps(mdur[m], minc[m], macc[m]);
    end
    check_bit("buffer_ready", buffer_ready, 1'b0);
    // Ring full, this one is dropped
    send_move(1'b0, 64'd8, 64'h8000_0000, 64'd0);
    check_bit("buffer_ready", buffer_ready, 1'b0);
    halt = 1'b0;
    wait (done_cnt == dbase + 4);
    repeat (2000) @(negedge CLK);
    check_count("move_done", done_cnt - dbase, 4);
    check_count("step", step_cnt - sbase, exp_steps);
    check_bit("buffer_ready", buffer_ready, 1'b1);

    // Long move frozen part way through
    sbase = step_cnt;
    dbase = done_cnt;
    dir_q.push_back(1'b1);
    send_move(1'b1, 64'd200, 64'h4000_0000, 64'd0);
    repeat (300) @(negedge CLK);
    halt = 1'b1;
    repeat (2) @(negedge CLK);
    held = step_cnt;
    repeat (600) @(negedge CLK);
    check_count("step", step_cnt - held, 0);
    halt = 1'b0;
    wait (done_cnt == dbase + 1);
    repeat (40) @(negedge CLK);
    check_count("step", step_cnt - sbase, ref_dda_steps(64'd200, 64'h4000_0000, 64'd0));

    $display("Checks: %0d, errors: %0d, steps: %0d, moves done: %0d",
             check_cnt, err_cnt, step_cnt, done_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
rtl/motion_pkg.sv
rtl/move_if.sv
rtl/spi_word.sv
rtl/cmd_decoder.sv
rtl/dda_timer.sv
rtl/motion_core.sv
tb/motion_asserts.sv
tb/tb_motion_core.sv

/* Makefile */
TOP := tb_motion_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
